/* Bender.yml */
package:
  name: hdmi_text_regs

sources:
  # packages first, then leaf modules, then the top level
  - files:
      - source/axi_lite_pkg.sv
      - source/text_vram_pkg.sv
      - source/palette_regs.sv
      - source/vram_dual_port.sv
      - source/axi_lite_ctrl.sv
      - source/hdmi_text_regs_top.sv

  # testbench, top module tb_hdmi_text_regs
  - target: test
    files:
      - verif/tb_hdmi_text_regs.sv

/* all.f */
source/axi_lite_pkg.sv
source/text_vram_pkg.sv
source/palette_regs.sv
source/vram_dual_port.sv
source/axi_lite_ctrl.sv
source/hdmi_text_regs_top.sv
verif/tb_hdmi_text_regs.sv

/* source/axi_lite_ctrl.sv */
`default_nettype none

module axi_lite_ctrl
  import axi_lite_pkg::*, text_vram_pkg::*;
#(
  parameter int data_width = axi_data_width,
  parameter int addr_width = axi_addr_width,
  parameter int vram_depth = vram_words
)
(
  input  wire logic                          S_AXI_ACLK,
  input  wire logic                          S_AXI_ARESETN,
  input  wire logic [addr_width-1:0]         S_AXI_AWADDR,
  input  wire logic                          S_AXI_AWVALID,
  output logic                               S_AXI_AWREADY,
  input  wire logic [data_width-1:0]         S_AXI_WDATA,
  input  wire logic [data_width/8-1:0]       S_AXI_WSTRB,
  input  wire logic                          S_AXI_WVALID,
  output logic                               S_AXI_WREADY,
  output axi_resp_t                          S_AXI_BRESP,
  output logic                               S_AXI_BVALID,
  input  wire logic                          S_AXI_BREADY,
  input  wire logic [addr_width-1:0]         S_AXI_ARADDR,
  input  wire logic                          S_AXI_ARVALID,
  output logic                               S_AXI_ARREADY,
  output logic [data_width-1:0]              S_AXI_RDATA,
  output axi_resp_t                          S_AXI_RRESP,
  output logic                               S_AXI_RVALID,
  input  wire logic                          S_AXI_RREADY,
  input  wire logic [data_width-1:0]         vram_rdata,
  input  wire logic [data_width-1:0]         pal_rdata,
  output logic [vram_index_bits-1:0]         mem_index,
  output logic [data_width-1:0]              mem_wdata,
  output logic [data_width/8-1:0]            mem_wstrb,
  output logic                               vram_we,
  output logic                               vram_re,
  output logic                               pal_we
);

  localparam int strb_width = data_width / 8;
  // full vram word index, every bit below the palette select bit
  localparam int word_bits = palette_sel_bit - addr_lsb;

  typedef enum logic [2:0] {
    idle,
    write_accept,
    wait_1,
    wait_2,
    wait_3,
    resp_b,
    read_accept,
    resp_r
  } state_t;

  state_t state;
  state_t state_next;

  logic                       write_start;
  logic                       read_start;
  logic [addr_width-1:0]      req_addr;
  logic [word_bits-1:0]       req_word;
  logic                       req_pal;
  logic                       req_oob;
  logic                       pal_sel_q;
  axi_resp_t                  resp_q;
  logic                       resp_ok;
  logic [vram_index_bits-1:0] index_q;
  logic [data_width-1:0]      wdata_q;
  logic [strb_width-1:0]      wstrb_q;
  logic                       rvalid_q;
  logic [data_width-1:0]      rdata_q;

  //////////////////////////////
  // request decode
  //////////////////////////////

  // write wins when both channels present at once
  assign write_start = S_AXI_AWVALID && S_AXI_WVALID;
  assign read_start = S_AXI_ARVALID && !write_start;
  assign req_addr = write_start ? S_AXI_AWADDR : S_AXI_ARADDR;
  assign req_word = req_addr[addr_lsb +: word_bits];
  assign req_pal = req_addr[palette_sel_bit];
  // vram index past the text buffer gets an error
  assign req_oob = !req_pal && (req_word >= vram_depth);

  // decode flags, captured once while idle
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      pal_sel_q <= 1'b0;
      resp_q <= resp_okay;
    end
    else if (state == idle)
    begin
      pal_sel_q <= req_pal;
      resp_q <= req_oob ? resp_slverr : resp_okay;
    end
  end

  // address and write payload, held for the whole transaction
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (state == idle)
    begin
      index_q <= req_addr[addr_lsb +: vram_index_bits];
      wdata_q <= S_AXI_WDATA;
      wstrb_q <= S_AXI_WSTRB;
    end
  end

  assign resp_ok = (resp_q == resp_okay);

  //////////////////////////////
  // transaction fsm
  //////////////////////////////

  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      state <= idle;
    else
      state <= state_next;
  end

  always_comb
  begin
    state_next = state;
    case (state)
      idle:
      begin
        if (write_start)
          state_next = write_accept;
        else if (read_start)
          state_next = read_accept;
      end
      // three wait states before the write response
      write_accept: state_next = wait_1;
      wait_1: state_next = wait_2;
      wait_2: state_next = wait_3;
      wait_3: state_next = resp_b;
      resp_b:
      begin
        if (S_AXI_BREADY)
          state_next = idle;
      end
      read_accept: state_next = resp_r;
      resp_r:
      begin
        if (rvalid_q && S_AXI_RREADY)
          state_next = idle;
      end
      default: state_next = idle;
    endcase
  end

  //////////////////////////////
  // read response
  //////////////////////////////

  // vram data arrives one edge after read_accept, loaded on the next
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
      rvalid_q <= 1'b0;
    else if ((state == resp_r) && !rvalid_q)
      rvalid_q <= 1'b1;
    else if (rvalid_q && S_AXI_RREADY)
      rvalid_q <= 1'b0;
  end

  always_ff @(posedge S_AXI_ACLK)
  begin
    if ((state == resp_r) && !rvalid_q)
    begin
      // out of range reads return zero
      if (!resp_ok)
        rdata_q <= '0;
      else if (pal_sel_q)
        rdata_q <= pal_rdata;
      else
        rdata_q <= vram_rdata;
    end
  end

  // host side handshakes straight from the state
  assign S_AXI_AWREADY = (state == write_accept);
  assign S_AXI_WREADY = (state == write_accept);
  assign S_AXI_ARREADY = (state == read_accept);
  assign S_AXI_BVALID = (state == resp_b);
  assign S_AXI_BRESP = resp_q;
  assign S_AXI_RVALID = rvalid_q;
  assign S_AXI_RDATA = rdata_q;
  assign S_AXI_RRESP = resp_q;

  // datapath strobes, range already checked here
  assign mem_index = index_q;
  assign mem_wdata = wdata_q;
  assign mem_wstrb = wstrb_q;
  assign vram_we = (state == write_accept) && !pal_sel_q && resp_ok;
  assign vram_re = (state == read_accept) && !pal_sel_q && resp_ok;
  assign pal_we = (state == write_accept) && pal_sel_q;

endmodule

`default_nettype wire

/* source/axi_lite_pkg.sv */
`default_nettype none

// definitions for the axi4-lite host side of the text controller
package axi_lite_pkg;

  //////////////////////////////
  // bus widths
  //////////////////////////////

  // data bus width in bits
  localparam int axi_data_width = 32;
  // byte address width
  localparam int axi_addr_width = 16;
  // one write strobe per byte lane
  localparam int axi_strb_width = axi_data_width / 8;

  //////////////////////////////
  // response codes
  //////////////////////////////

  typedef logic [1:0] axi_resp_t;

  // normal completion
  localparam axi_resp_t resp_okay = 2'b00;
  // slave error, used for accesses past the text buffer
  localparam axi_resp_t resp_slverr = 2'b10;

endpackage

`default_nettype wire

/* source/hdmi_text_regs_top.sv */
`default_nettype none

module hdmi_text_regs_top
  import axi_lite_pkg::*, text_vram_pkg::*;
#(
  parameter int data_width = axi_data_width,
  parameter int addr_width = axi_addr_width,
  parameter int vram_depth = vram_words
)
(
  input  wire logic                       S_AXI_ACLK,
  input  wire logic                       S_AXI_ARESETN,
  // write address
  input  wire logic [addr_width-1:0]      S_AXI_AWADDR,
  input  wire logic                       S_AXI_AWVALID,
  output logic                            S_AXI_AWREADY,
  // write data
  input  wire logic [data_width-1:0]      S_AXI_WDATA,
  input  wire logic [data_width/8-1:0]    S_AXI_WSTRB,
  input  wire logic                       S_AXI_WVALID,
  output logic                            S_AXI_WREADY,
  // write response
  output axi_resp_t                       S_AXI_BRESP,
  output logic                            S_AXI_BVALID,
  input  wire logic                       S_AXI_BREADY,
  // read address
  input  wire logic [addr_width-1:0]      S_AXI_ARADDR,
  input  wire logic                       S_AXI_ARVALID,
  output logic                            S_AXI_ARREADY,
  // read data
  output logic [data_width-1:0]           S_AXI_RDATA,
  output axi_resp_t                       S_AXI_RRESP,
  output logic                            S_AXI_RVALID,
  input  wire logic                       S_AXI_RREADY,
  // display read port
  input  wire logic [vram_index_bits-1:0] disp_index,
  output logic [data_width-1:0]           disp_word
);

  // shared datapath lines from the controller
  logic [vram_index_bits-1:0] mem_index;
  logic [data_width-1:0]      mem_wdata;
  logic [data_width/8-1:0]    mem_wstrb;
  logic                       vram_we;
  logic                       vram_re;
  logic                       pal_we;
  logic [data_width-1:0]      vram_rdata;
  logic [data_width-1:0]      pal_rdata;

  //////////////////////////////
  // bus control
  //////////////////////////////

  axi_lite_ctrl #(
    .data_width (data_width),
    .addr_width (addr_width),
    .vram_depth (vram_depth)
  ) axi_lite_ctrl_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (S_AXI_AWADDR),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WDATA   (S_AXI_WDATA),
    .S_AXI_WSTRB   (S_AXI_WSTRB),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_ARADDR  (S_AXI_ARADDR),
    .S_AXI_ARVALID (S_AXI_ARVALID),
    .S_AXI_ARREADY (S_AXI_ARREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .S_AXI_RRESP   (S_AXI_RRESP),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY),
    .vram_rdata    (vram_rdata),
    .pal_rdata     (pal_rdata),
    .mem_index     (mem_index),
    .mem_wdata     (mem_wdata),
    .mem_wstrb     (mem_wstrb),
    .vram_we       (vram_we),
    .vram_re       (vram_re),
    .pal_we        (pal_we)
  );

  //////////////////////////////
  // storage
  //////////////////////////////

  vram_dual_port #(
    .data_width (data_width),
    .vram_depth (vram_depth)
  ) vram_dual_port_i (
    .S_AXI_ACLK (S_AXI_ACLK),
    .mem_index  (mem_index),
    .mem_wdata  (mem_wdata),
    .mem_wstrb  (mem_wstrb),
    .vram_we    (vram_we),
    .vram_re    (vram_re),
    .vram_rdata (vram_rdata),
    .disp_index (disp_index),
    .disp_word  (disp_word)
  );

  // palette sees only the low index bits
  palette_regs palette_regs_i (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .pal_index     (mem_index[palette_index_bits-1:0]),
    .mem_wdata     (mem_wdata),
    .mem_wstrb     (mem_wstrb),
    .pal_we        (pal_we),
    .pal_rdata     (pal_rdata)
  );

endmodule

`default_nettype wire

/* source/palette_regs.sv */
`default_nettype none

module palette_regs
  import axi_lite_pkg::*, text_vram_pkg::*;
(
  input  wire logic                          S_AXI_ACLK,
  input  wire logic                          S_AXI_ARESETN,
  input  wire logic [palette_index_bits-1:0] pal_index,
  input  wire logic [axi_data_width-1:0]     mem_wdata,
  input  wire logic [axi_strb_width-1:0]     mem_wstrb,
  input  wire logic                          pal_we,
  output logic [axi_data_width-1:0]          pal_rdata
);

  // colour entries
  logic [axi_data_width-1:0] pal_q [palette_words];

  //////////////////////////////
  // write side
  //////////////////////////////

  // all entries black after reset
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (!S_AXI_ARESETN)
    begin
      for (int e = 0; e < palette_words; e++)
        pal_q[e] <= '0;
    end
    else if (pal_we)
    begin
      // each enabled lane on its own
      for (int i = 0; i < axi_strb_width; i++)
      begin
        if (mem_wstrb[i])
          pal_q[pal_index][i*8 +: 8] <= mem_wdata[i*8 +: 8];
      end
    end
  end

  // combinational read, registered in the controller
  assign pal_rdata = pal_q[pal_index];

endmodule

`default_nettype wire

/* source/text_vram_pkg.sv */
`default_nettype none

// memory map of the text mode controller
package text_vram_pkg;

  // word index starts above the byte offset bits
  localparam int addr_lsb = 2;

  //////////////////////////////
  // vram region
  //////////////////////////////

  // four character cells per word, 80 x 30 screen
  localparam int vram_words = 600;
  // word index width, limits the buffer to 1024 words
  localparam int vram_index_bits = 10;

  //////////////////////////////
  // palette region
  //////////////////////////////

  // byte address bit that steers an access to the palette
  localparam int palette_sel_bit = 13;
  // colour entries in the palette file
  localparam int palette_words = 8;
  localparam int palette_index_bits = 3;

endpackage

`default_nettype wire

/* source/vram_dual_port.sv */
`default_nettype none

module vram_dual_port
  import axi_lite_pkg::*, text_vram_pkg::*;
#(
  parameter int data_width = axi_data_width,
  parameter int vram_depth = vram_words
)
(
  input  wire logic                       S_AXI_ACLK,
  // host port
  input  wire logic [vram_index_bits-1:0] mem_index,
  input  wire logic [data_width-1:0]      mem_wdata,
  input  wire logic [data_width/8-1:0]    mem_wstrb,
  input  wire logic                       vram_we,
  input  wire logic                       vram_re,
  output logic [data_width-1:0]           vram_rdata,
  // display port
  input  wire logic [vram_index_bits-1:0] disp_index,
  output logic [data_width-1:0]           disp_word
);

  localparam int strb_width = data_width / 8;

  // character words, no reset so it maps to block ram
  logic [data_width-1:0] mem [vram_depth];

  //////////////////////////////
  // host port
  //////////////////////////////

  // byte lanes written per strobe
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (vram_we)
    begin
      for (int i = 0; i < strb_width; i++)
      begin
        if (mem_wstrb[i])
          mem[mem_index][i*8 +: 8] <= mem_wdata[i*8 +: 8];
      end
    end
  end

  // registered host read
  always_ff @(posedge S_AXI_ACLK)
  begin
    if (vram_re)
      vram_rdata <= mem[mem_index];
  end

  //////////////////////////////
  // display port
  //////////////////////////////

  // read first, a same cycle host write shows up a cycle later
  always_ff @(posedge S_AXI_ACLK)
  begin
    disp_word <= mem[disp_index];
  end

endmodule

`default_nettype wire

/* verif/tb_hdmi_text_regs.sv */
`default_nettype none

module tb_hdmi_text_regs
  import axi_lite_pkg::*, text_vram_pkg::*;
;

  // bound on every wait loop in clock cycles
  localparam int max_wait = 64;
  localparam int index_limit = 1 << vram_index_bits;
  localparam int pal_base = 1 << palette_sel_bit;

  logic S_AXI_ACLK;
  logic S_AXI_ARESETN;
  logic [axi_addr_width-1:0] S_AXI_AWADDR;
  logic S_AXI_AWVALID;
  logic S_AXI_AWREADY;
  logic [axi_data_width-1:0] S_AXI_WDATA;
  logic [axi_strb_width-1:0] S_AXI_WSTRB;
  logic S_AXI_WVALID;
  logic S_AXI_WREADY;
  axi_resp_t S_AXI_BRESP;
  logic S_AXI_BVALID;
  logic S_AXI_BREADY;
  logic [axi_addr_width-1:0] S_AXI_ARADDR;
  logic S_AXI_ARVALID;
  logic S_AXI_ARREADY;
  logic [axi_data_width-1:0] S_AXI_RDATA;
  axi_resp_t S_AXI_RRESP;
  logic S_AXI_RVALID;
  logic S_AXI_RREADY;
  logic [vram_index_bits-1:0] disp_index;
  logic [axi_data_width-1:0] disp_word;

  // reference model
  logic [31:0] vram_model [index_limit];
  bit written [index_limit];
  logic [31:0] pal_model [palette_words];

  logic [31:0] lfsr = 32'hcc8a;
  int errors = 0;
  int checks = 0;
  int tests = 0;
  int errs0;
  int idx;
  event timeout_ev;

  hdmi_text_regs_top hdmi_text_regs_top_i (.*);

  initial
  begin
    S_AXI_ACLK = 1'b0;
    forever #2 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  // galois lfsr stepped once per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
    begin
      r = {r[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return r;
  endfunction

  // byte lanes of data replace old where strobed
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] r;
    r = old;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
        r[i*8 +: 8] = data[i*8 +: 8];
    end
    return r;
  endfunction

  // inputs change one unit after the edge
  task automatic step();
    @(posedge S_AXI_ACLK);
    #1;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("** Error at %0t: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic hang(input string what);
    $display("timeout at %0t, %s never came", $time, what);
    -> timeout_ev;
  endtask

  task automatic report_test(input string name);
    tests++;
    $display("test %0d %s done, %0d errors", tests, name, errors - errs0);
  endtask

  //////////////////////////////
  // bus transactions
  //////////////////////////////

  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input int hold, input axi_resp_t exp_resp);
    int n;
    int edges;
    S_AXI_AWADDR = addr;
    S_AXI_WDATA = data;
    S_AXI_WSTRB = strb;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID = 1'b1;
    n = 0;
    step();
    while (!S_AXI_AWREADY && n < max_wait)
    begin
      step();
      n++;
    end
    if (!S_AXI_AWREADY)
      hang("AWREADY");
    check_val("S_AXI_WREADY", 1, S_AXI_WREADY);
    // handshake ends at the next edge
    step();
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID = 1'b0;
    edges = 1;
    while (!S_AXI_BVALID && edges < max_wait)
    begin
      step();
      edges++;
    end
    if (!S_AXI_BVALID)
      hang("BVALID");
    // counted from the edge that raised AWREADY
    check_val("BVALID latency", 4, edges);
    check_val("S_AXI_BRESP", exp_resp, S_AXI_BRESP);
    // response must hold under back-pressure
    for (int i = 0; i < hold; i++)
    begin
      step();
      check_val("S_AXI_BVALID", 1, S_AXI_BVALID);
      check_val("S_AXI_BRESP", exp_resp, S_AXI_BRESP);
    end
    S_AXI_BREADY = 1'b1;
    step();
    S_AXI_BREADY = 1'b0;
    check_val("S_AXI_BVALID", 0, S_AXI_BVALID);
  endtask

  task automatic axi_read(input logic [15:0] addr, input int hold, input axi_resp_t exp_resp,
                          input logic [31:0] exp_data);
    int n;
    int edges;
    S_AXI_ARADDR = addr;
    S_AXI_ARVALID = 1'b1;
    n = 0;
    step();
    while (!S_AXI_ARREADY && n < max_wait)
    begin
      step();
      n++;
    end
    if (!S_AXI_ARREADY)
      hang("ARREADY");
    step();
    S_AXI_ARVALID = 1'b0;
    edges = 1;
    while (!S_AXI_RVALID && edges < max_wait)
    begin
      step();
      edges++;
    end
    if (!S_AXI_RVALID)
      hang("RVALID");
    check_val("RVALID latency", 2, edges);
    check_val("S_AXI_RRESP", exp_resp, S_AXI_RRESP);
    check_val("S_AXI_RDATA", exp_data, S_AXI_RDATA);
    for (int i = 0; i < hold; i++)
    begin
      step();
      check_val("S_AXI_RVALID", 1, S_AXI_RVALID);
      check_val("S_AXI_RRESP", exp_resp, S_AXI_RRESP);
      check_val("S_AXI_RDATA", exp_data, S_AXI_RDATA);
    end
    S_AXI_RREADY = 1'b1;
    step();
    S_AXI_RREADY = 1'b0;
    check_val("S_AXI_RVALID", 0, S_AXI_RVALID);
  endtask

  // random in-range vram write and its model update
  task automatic write_vram(input int i, input int hold);
    logic [31:0] data;
    logic [3:0] strb;
    data = rand_bits(32);
    strb = rand_bits(4);
    axi_write(16'(i << addr_lsb), data, strb, hold, resp_okay);
    vram_model[i] = merge_bytes(vram_model[i], data, strb);
    written[i] = 1'b1;
  endtask

  task automatic check_vram_all();
    for (int i = 0; i < vram_words; i++)
    begin
      if (written[i])
        axi_read(16'(i << addr_lsb), rand_bits(2), resp_okay, vram_model[i]);
    end
  endtask

  //////////////////////////////
  // test sequence
  //////////////////////////////

  initial
  begin
    @(timeout_ev);
    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors + 1);
    $display("Finished with errors");
    $finish;
  end

  initial
  begin
    S_AXI_ARESETN = 1'b0;
    S_AXI_AWADDR = '0;
    S_AXI_AWVALID = 1'b0;
    S_AXI_WDATA = '0;
    S_AXI_WSTRB = '0;
    S_AXI_WVALID = 1'b0;
    S_AXI_BREADY = 1'b0;
    S_AXI_ARADDR = '0;
    S_AXI_ARVALID = 1'b0;
    S_AXI_RREADY = 1'b0;
    disp_index = '0;
    for (int e = 0; e < palette_words; e++)
      pal_model[e] = '0;
    repeat (16) @(posedge S_AXI_ACLK);
    #1;
    S_AXI_ARESETN = 1'b1;

    // quiet bus and black palette after reset
    errs0 = errors;
    check_val("S_AXI_BVALID", 0, S_AXI_BVALID);
    check_val("S_AXI_RVALID", 0, S_AXI_RVALID);
    check_val("S_AXI_AWREADY", 0, S_AXI_AWREADY);
    check_val("S_AXI_WREADY", 0, S_AXI_WREADY);
    check_val("S_AXI_ARREADY", 0, S_AXI_ARREADY);
    for (int e = 0; e < palette_words; e++)
      axi_read(16'(pal_base | (e << addr_lsb)), 0, resp_okay, 32'h0);
    report_test("reset state");

    errs0 = errors;
    for (int k = 0; k < 40; k++)
      write_vram(rand_bits(10) % vram_words, rand_bits(2));
    check_vram_all();
    report_test("vram write and read back");

    // palette traffic must not touch vram
    errs0 = errors;
    // the low vram words share their index bits with the palette entries
    for (int e = 0; e < palette_words; e++)
    begin
      vram_model[e] = rand_bits(32);
      written[e] = 1'b1;
      axi_write(16'(e << addr_lsb), vram_model[e], 4'hf, 0, resp_okay);
    end
    for (int k = 0; k < 24; k++)
    begin
      logic [31:0] data;
      logic [3:0] strb;
      data = rand_bits(32);
      strb = rand_bits(4);
      idx = rand_bits(3);
      axi_write(16'(pal_base | (idx << addr_lsb)), data, strb, rand_bits(2), resp_okay);
      pal_model[idx] = merge_bytes(pal_model[idx], data, strb);
    end
    for (int e = 0; e < palette_words; e++)
      axi_read(16'(pal_base | (e << addr_lsb)), rand_bits(2), resp_okay, pal_model[e]);
    check_vram_all();
    report_test("palette access");

    // indices past the text buffer
    errs0 = errors;
    for (int k = 0; k < 16; k++)
    begin
      idx = vram_words + rand_bits(10) % (index_limit - vram_words);
      axi_write(16'(idx << addr_lsb), rand_bits(32), 4'hf, rand_bits(2), resp_slverr);
      axi_read(16'(idx << addr_lsb), rand_bits(2), resp_slverr, 32'h0);
    end
    check_vram_all();
    report_test("out of range");

    errs0 = errors;
    for (int k = 0; k < 12; k++)
    begin
      idx = rand_bits(10) % vram_words;
      write_vram(idx, rand_bits(2));
      disp_index = idx[vram_index_bits-1:0];
      step();
      check_val("disp_word", vram_model[idx], disp_word);
    end
    report_test("display port");

    // long ready stalls on both channels
    errs0 = errors;
    for (int k = 0; k < 20; k++)
    begin
      idx = rand_bits(10) % vram_words;
      write_vram(idx, rand_bits(4));
      axi_read(16'(idx << addr_lsb), rand_bits(4), resp_okay, vram_model[idx]);
    end
    report_test("back-pressure and timing");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

`default_nettype wire
